// ==== source/workgroup_consts.svh ====
`ifndef WORKGROUP_CONSTS_SVH
`define WORKGROUP_CONSTS_SVH

// Workgroup size
`define WG_CPU_MAX          4       // Hart slots, populated or not
`define WG_CPU_NUM_DEFAULT  3
`define WG_REG_TOTAL        16      // Registers per hart

// Cycles an access may wait for a slot before it is aborted
`define WG_DPORT_TIMEOUT    32

// AXI4-Lite register offsets, decoded on address bits 7:0
`define WG_ADDR_CONTROL     8'h00
`define WG_ADDR_STATUS      8'h04
`define WG_ADDR_DADDR       8'h08
`define WG_ADDR_WDATA       8'h0C
`define WG_ADDR_COMMAND     8'h10
`define WG_ADDR_RDATA       8'h14

`endif

// ==== source/workgroup_pkg.sv ====
`default_nettype none

package workgroup_pkg;

    typedef logic [1:0] hartsel_t;      // Hart slot index

    // AXI4-Lite master to slave
    typedef struct packed {
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [31:0] araddr;
        logic        arvalid;
        logic        rready;
    } axil_m2s_t;

    // AXI4-Lite slave to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        arready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_s2m_t;

    typedef struct packed {
        logic        write;             // Register write when set, read otherwise
        logic [3:0]  index;
        logic [31:0] wdata;
    } dport_req_t;

    typedef struct packed {
        logic        error;
        logic [31:0] rdata;
    } dport_resp_t;

    typedef struct packed {
        logic haltreq;
        logic resumereq;
    } hart_ctrl_t;

    typedef struct packed {
        logic halted;
        logic available;
    } hart_status_t;

endpackage

`default_nettype wire

// ==== source/dmi_axil_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "workgroup_consts.svh"

module dmi_axil_regs (
    input logic i_clk,
    input logic i_rst_n,
    input workgroup_pkg::axil_m2s_t i_axil,
    output workgroup_pkg::axil_s2m_t o_axil,
    output workgroup_pkg::hartsel_t o_hartsel,
    output workgroup_pkg::hart_ctrl_t o_hart_ctrl,
    output logic o_start,                           // One-cycle transaction start
    output workgroup_pkg::dport_req_t o_req,
    input logic i_busy,
    input logic i_done,
    input logic i_error,
    input logic i_timeout,
    input logic [31:0] i_rdata,
    input workgroup_pkg::hart_status_t i_status [`WG_CPU_MAX]
);

import workgroup_pkg::*;

hartsel_t hartsel_q;
hart_ctrl_t ctrl_q;
logic [3:0] daddr_q;
logic [31:0] wdata_q;
logic cmd_write_q;
logic start_q;
logic [31:0] rdata_q;
logic bvalid_q;
logic rvalid_q;
logic [31:0] axi_rdata_q;
logic wr_acc;
logic rd_acc;
logic [31:0] status;
logic [31:0] rd_mux;

// Byte lanes not enabled by the strobe keep their old value
function automatic logic [31:0] merge_strb(input logic [31:0] old_v,
                                           input logic [31:0] new_v,
                                           input logic [3:0] strb);
    logic [31:0] res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
            res[8*b +: 8] = new_v[8*b +: 8];
        end
    end
    return res;
endfunction

assign wr_acc = i_axil.awvalid && i_axil.wvalid && !bvalid_q;  // AW and W taken together
assign rd_acc = i_axil.arvalid && !rvalid_q;

always_comb begin
    status = '0;
    for (int i = 0; i < `WG_CPU_MAX; i++) begin
        status[i]     = i_status[i].halted;
        status[8 + i] = i_status[i].available;
    end
    status[16] = i_busy || start_q;                 // Covers the cycle before the FSM leaves IDLE
    status[17] = i_error;
    status[18] = i_timeout;
end

always_comb begin
    case (i_axil.araddr[7:0])
        `WG_ADDR_CONTROL: rd_mux = {30'd0, hartsel_q};
        `WG_ADDR_STATUS:  rd_mux = status;
        `WG_ADDR_DADDR:   rd_mux = {28'd0, daddr_q};
        `WG_ADDR_WDATA:   rd_mux = wdata_q;
        `WG_ADDR_COMMAND: rd_mux = {31'd0, cmd_write_q};
        `WG_ADDR_RDATA:   rd_mux = rdata_q;
        default:          rd_mux = '0;
    endcase
end

// Register map writes
always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        hartsel_q   <= '0;
        ctrl_q      <= '0;
        daddr_q     <= '0;
        wdata_q     <= '0;
        cmd_write_q <= 1'b0;
        start_q     <= 1'b0;
        rdata_q     <= '0;
    end else begin
        ctrl_q  <= '0;                              // Halt and resume are pulses
        start_q <= 1'b0;
        if (wr_acc) begin
            case (i_axil.awaddr[7:0])
                `WG_ADDR_CONTROL: begin
                    if (i_axil.wstrb[0]) begin
                        hartsel_q        <= i_axil.wdata[1:0];
                        ctrl_q.haltreq   <= i_axil.wdata[4];
                        ctrl_q.resumereq <= i_axil.wdata[5];
                    end
                end
                `WG_ADDR_DADDR: begin
                    if (i_axil.wstrb[0]) begin
                        daddr_q <= i_axil.wdata[3:0];
                    end
                end
                `WG_ADDR_WDATA: wdata_q <= merge_strb(wdata_q, i_axil.wdata, i_axil.wstrb);
                `WG_ADDR_COMMAND: begin
                    // A command while a transaction runs is dropped
                    if (!i_busy && !start_q) begin
                        cmd_write_q <= i_axil.wdata[0];
                        start_q     <= 1'b1;
                    end
                end
                default: ;
            endcase
        end
        if (i_done) begin
            rdata_q <= i_rdata;
        end
    end
end

// Write and read response channels
always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        bvalid_q <= 1'b0;
        rvalid_q <= 1'b0;
    end else begin
        if (wr_acc) begin
            bvalid_q <= 1'b1;
        end else if (i_axil.bready) begin
            bvalid_q <= 1'b0;
        end
        if (rd_acc) begin
            rvalid_q <= 1'b1;
        end else if (i_axil.rready) begin
            rvalid_q <= 1'b0;
        end
    end
end

always_ff @(posedge i_clk) begin
    if (rd_acc) begin
        axi_rdata_q <= rd_mux;
    end
end

assign o_axil.awready = wr_acc;
assign o_axil.wready  = wr_acc;
assign o_axil.arready = !rvalid_q;
assign o_axil.bvalid  = bvalid_q;
assign o_axil.bresp   = 2'b00;                      // OKAY
assign o_axil.rvalid  = rvalid_q;
assign o_axil.rdata   = axi_rdata_q;
assign o_axil.rresp   = 2'b00;

assign o_hartsel   = hartsel_q;
assign o_hart_ctrl = ctrl_q;
assign o_start     = start_q;
assign o_req       = '{write: cmd_write_q, index: daddr_q, wdata: wdata_q};

endmodule

`default_nettype wire

// ==== source/dport_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module dport_fsm (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_start,
    output logic o_busy,
    output logic o_done,
    output logic o_error,
    output logic o_timeout,
    output logic [31:0] o_rdata,
    output logic o_req_valid,
    input logic i_req_ready,
    output logic o_resp_ready,
    input logic i_resp_valid,
    input workgroup_pkg::dport_resp_t i_resp,
    output logic o_timer_en,
    input logic i_expired
);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_RESPONSE,
    ST_DONE
} state_t;

state_t state_q;
state_t state_d;
logic error_q;
logic timeout_q;
logic [31:0] rdata_q;
logic capture;
logic abort;

assign capture = (state_q == ST_RESPONSE) && i_resp_valid;
// An accepted request or a returned response wins over expiry in the same cycle
assign abort = i_expired && (((state_q == ST_REQUEST) && !i_req_ready) ||
                             ((state_q == ST_RESPONSE) && !i_resp_valid));

always_comb begin
    state_d = state_q;
    case (state_q)
        ST_IDLE: begin
            if (i_start) begin
                state_d = ST_REQUEST;
            end
        end
        ST_REQUEST: begin
            if (i_req_ready) begin
                state_d = ST_RESPONSE;
            end else if (abort) begin
                state_d = ST_DONE;
            end
        end
        ST_RESPONSE: begin
            if (capture || abort) begin
                state_d = ST_DONE;
            end
        end
        default: state_d = i_start ? ST_REQUEST : ST_IDLE;   // DONE lasts one cycle
    endcase
end

always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        state_q   <= ST_IDLE;
        error_q   <= 1'b0;
        timeout_q <= 1'b0;
    end else begin
        state_q <= state_d;
        if (i_start && !o_busy) begin
            error_q   <= 1'b0;                      // Flags belong to the last transaction
            timeout_q <= 1'b0;
        end else if (capture) begin
            error_q <= i_resp.error;
        end else if (abort) begin
            error_q   <= 1'b1;
            timeout_q <= 1'b1;
        end
    end
end

always_ff @(posedge i_clk) begin
    if (capture) begin
        rdata_q <= i_resp.rdata;
    end else if (abort) begin
        rdata_q <= '0;
    end
end

assign o_busy       = (state_q == ST_REQUEST) || (state_q == ST_RESPONSE);
assign o_done       = (state_q == ST_DONE);
assign o_error      = error_q;
assign o_timeout    = timeout_q;
assign o_rdata      = rdata_q;
assign o_req_valid  = (state_q == ST_REQUEST);
assign o_resp_ready = (state_q == ST_RESPONSE);
assign o_timer_en   = o_busy;                       // Runs for the whole access

endmodule

`default_nettype wire

// ==== source/dport_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "workgroup_consts.svh"

module dport_timer (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_en,
    output logic o_expired
);

localparam int CNT_W = $clog2(`WG_DPORT_TIMEOUT);

logic [CNT_W-1:0] cnt_q;

always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        cnt_q <= '0;
    end else if (!i_en) begin
        cnt_q <= '0;                                // Restart for every access
    end else if (!o_expired) begin
        cnt_q <= cnt_q + 1'b1;
    end
end

// Set in the last of WG_DPORT_TIMEOUT enabled cycles, then held
assign o_expired = (cnt_q == CNT_W'(`WG_DPORT_TIMEOUT - 1));

endmodule

`default_nettype wire

// ==== source/dport_ic.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "workgroup_consts.svh"

module dport_ic #(
    parameter int unsigned CPU_NUM = `WG_CPU_NUM_DEFAULT
) (
    input workgroup_pkg::hartsel_t i_hartsel,
    input workgroup_pkg::hart_ctrl_t i_hart_ctrl,
    input logic i_req_valid,
    input workgroup_pkg::dport_req_t i_req,
    output logic o_req_ready,
    input logic i_resp_ready,
    output logic o_resp_valid,
    output workgroup_pkg::dport_resp_t o_resp,
    output logic o_hart_req_valid [`WG_CPU_MAX],
    output workgroup_pkg::dport_req_t o_hart_req [`WG_CPU_MAX],
    input logic i_hart_req_ready [`WG_CPU_MAX],
    output logic o_hart_resp_ready [`WG_CPU_MAX],
    input logic i_hart_resp_valid [`WG_CPU_MAX],
    input workgroup_pkg::dport_resp_t i_hart_resp [`WG_CPU_MAX],
    output workgroup_pkg::hart_ctrl_t o_hart_ctrl [`WG_CPU_MAX]
);

logic sel_populated;

assign sel_populated = (int'(i_hartsel) < CPU_NUM);

// Only the selected slot sees requests and control pulses
always_comb begin
    for (int i = 0; i < `WG_CPU_MAX; i++) begin
        o_hart_req_valid[i]  = 1'b0;
        o_hart_req[i]        = '0;
        o_hart_resp_ready[i] = 1'b0;
        o_hart_ctrl[i]       = '0;
        if (int'(i_hartsel) == i) begin
            o_hart_req_valid[i]  = i_req_valid;
            o_hart_req[i]        = i_req;
            o_hart_resp_ready[i] = i_resp_ready;
            o_hart_ctrl[i]       = i_hart_ctrl;
        end
    end
end

// Empty slots never answer, so the access runs into the timeout
assign o_req_ready  = sel_populated && i_hart_req_ready[i_hartsel];
assign o_resp_valid = sel_populated && i_hart_resp_valid[i_hartsel];
assign o_resp       = sel_populated ? i_hart_resp[i_hartsel] : '0;

endmodule

`default_nettype wire

// ==== source/hart_dport.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "workgroup_consts.svh"

module hart_dport (
    input logic i_clk,
    input logic i_rst_n,
    input workgroup_pkg::hart_ctrl_t i_ctrl,
    input logic i_req_valid,
    input workgroup_pkg::dport_req_t i_req,
    output logic o_req_ready,
    input logic i_resp_ready,
    output logic o_resp_valid,
    output workgroup_pkg::dport_resp_t o_resp,
    output workgroup_pkg::hart_status_t o_status
);

import workgroup_pkg::*;

logic [31:0] regs_q [`WG_REG_TOTAL];
logic halted_q;
logic resp_valid_q;
dport_resp_t resp_q;

always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        halted_q     <= 1'b0;                       // Harts come out of reset running
        resp_valid_q <= 1'b0;
        for (int i = 0; i < `WG_REG_TOTAL; i++) begin
            regs_q[i] <= '0;
        end
    end else begin
        if (i_ctrl.haltreq) begin
            halted_q <= 1'b1;
        end else if (i_ctrl.resumereq) begin
            halted_q <= 1'b0;
        end
        if (i_req_valid) begin
            resp_valid_q <= 1'b1;
            if (i_req.write && halted_q) begin
                regs_q[i_req.index] <= i_req.wdata;
            end
        end else if (i_resp_ready) begin
            resp_valid_q <= 1'b0;
        end
    end
end

// Response carries the register value seen before any write
always_ff @(posedge i_clk) begin
    if (i_req_valid) begin
        resp_q.error <= i_req.write && !halted_q;   // Running hart rejects writes
        resp_q.rdata <= regs_q[i_req.index];
    end
end

assign o_req_ready  = 1'b1;
assign o_resp_valid = resp_valid_q;
assign o_resp       = resp_q;
assign o_status     = '{halted: halted_q, available: 1'b1};

endmodule

`default_nettype wire

// ==== source/workgroup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "workgroup_consts.svh"

module workgroup #(
    parameter int unsigned CPU_NUM = `WG_CPU_NUM_DEFAULT
) (
    input logic i_clk,
    input logic i_rst_n,
    input workgroup_pkg::axil_m2s_t i_axil,
    output workgroup_pkg::axil_s2m_t o_axil
);

import workgroup_pkg::*;

hartsel_t w_hartsel;
hart_ctrl_t w_hart_ctrl;
dport_req_t w_req;
dport_resp_t w_resp;
logic w_start;
logic w_busy;
logic w_done;
logic w_error;
logic w_timeout;
logic [31:0] w_rdata;
logic w_req_valid;
logic w_req_ready;
logic w_resp_ready;
logic w_resp_valid;
logic w_timer_en;
logic w_expired;

// Per-slot debug port
logic w_hart_req_valid [`WG_CPU_MAX];
dport_req_t w_hart_req [`WG_CPU_MAX];
logic w_hart_req_ready [`WG_CPU_MAX];
logic w_hart_resp_ready [`WG_CPU_MAX];
logic w_hart_resp_valid [`WG_CPU_MAX];
dport_resp_t w_hart_resp [`WG_CPU_MAX];
hart_ctrl_t w_slot_ctrl [`WG_CPU_MAX];
hart_status_t w_status [`WG_CPU_MAX];

dmi_axil_regs regs0 (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_axil(i_axil),
    .o_axil(o_axil),
    .o_hartsel(w_hartsel),
    .o_hart_ctrl(w_hart_ctrl),
    .o_start(w_start),
    .o_req(w_req),
    .i_busy(w_busy),
    .i_done(w_done),
    .i_error(w_error),
    .i_timeout(w_timeout),
    .i_rdata(w_rdata),
    .i_status(w_status)
);

dport_fsm fsm0 (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_start(w_start),
    .o_busy(w_busy),
    .o_done(w_done),
    .o_error(w_error),
    .o_timeout(w_timeout),
    .o_rdata(w_rdata),
    .o_req_valid(w_req_valid),
    .i_req_ready(w_req_ready),
    .o_resp_ready(w_resp_ready),
    .i_resp_valid(w_resp_valid),
    .i_resp(w_resp),
    .o_timer_en(w_timer_en),
    .i_expired(w_expired)
);

dport_timer timer0 (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_en(w_timer_en),
    .o_expired(w_expired)
);

dport_ic #(
    .CPU_NUM(CPU_NUM)
) ic0 (
    .i_hartsel(w_hartsel),
    .i_hart_ctrl(w_hart_ctrl),
    .i_req_valid(w_req_valid),
    .i_req(w_req),
    .o_req_ready(w_req_ready),
    .i_resp_ready(w_resp_ready),
    .o_resp_valid(w_resp_valid),
    .o_resp(w_resp),
    .o_hart_req_valid(w_hart_req_valid),
    .o_hart_req(w_hart_req),
    .i_hart_req_ready(w_hart_req_ready),
    .o_hart_resp_ready(w_hart_resp_ready),
    .i_hart_resp_valid(w_hart_resp_valid),
    .i_hart_resp(w_hart_resp),
    .o_hart_ctrl(w_slot_ctrl)
);

for (genvar i = 0; i < CPU_NUM; i++) begin : xslotcpu
    hart_dport hartx (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_ctrl(w_slot_ctrl[i]),
        .i_req_valid(w_hart_req_valid[i]),
        .i_req(w_hart_req[i]),
        .o_req_ready(w_hart_req_ready[i]),
        .i_resp_ready(w_hart_resp_ready[i]),
        .o_resp_valid(w_hart_resp_valid[i]),
        .o_resp(w_hart_resp[i]),
        .o_status(w_status[i])
    );
end : xslotcpu

// Unpopulated slots are silent and report not available
for (genvar i = CPU_NUM; i < `WG_CPU_MAX; i++) begin : xemptyslot
    assign w_hart_req_ready[i]  = 1'b0;
    assign w_hart_resp_valid[i] = 1'b0;
    assign w_hart_resp[i]       = '0;
    assign w_status[i]          = '0;
end : xemptyslot

endmodule

`default_nettype wire

// ==== verification/tb_axil_tasks.svh ====
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

localparam int AXIL_WAIT_MAX = 16;                  // Cycles a channel may stall
localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

// AW and W presented together, response taken as soon as it shows
task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
    int cycles;
    logic seen;
    logic [1:0] resp;
    @(posedge clk);
    #1;
    axil_m2s.awaddr  = addr;
    axil_m2s.awvalid = 1'b1;
    axil_m2s.wdata   = data;
    axil_m2s.wstrb   = 4'hF;
    axil_m2s.wvalid  = 1'b1;
    axil_m2s.bready  = 1'b1;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < AXIL_WAIT_MAX) begin
        @(negedge clk);
        seen = axil_s2m.awready && axil_s2m.wready; // Taken at the coming edge
        @(posedge clk);
        cycles++;
    end
    #1;
    axil_m2s.awvalid = 1'b0;
    axil_m2s.wvalid  = 1'b0;
    if (!seen) begin
        $display("Write to offset 0x%02h was never accepted (time %0t)", addr[7:0], $time);
        n_timeouts++;
    end
    seen   = 1'b0;
    cycles = 0;
    resp   = AXIL_RESP_OKAY;
    while (!seen && cycles < AXIL_WAIT_MAX) begin
        @(negedge clk);
        seen = axil_s2m.bvalid;
        resp = axil_s2m.bresp;
        @(posedge clk);
        cycles++;
    end
    #1;
    axil_m2s.bready = 1'b0;
    if (!seen) begin
        $display("Write to offset 0x%02h got no write response (time %0t)", addr[7:0], $time);
        n_timeouts++;
    end else begin
        queue_check($sformatf("BRESP of write to offset 0x%02h", addr[7:0]),
                    32'(resp), 32'(AXIL_RESP_OKAY));
    end
endtask

task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
    int cycles;
    logic seen;
    logic [1:0] resp;
    data = '0;
    resp = AXIL_RESP_OKAY;
    @(posedge clk);
    #1;
    axil_m2s.araddr  = addr;
    axil_m2s.arvalid = 1'b1;
    axil_m2s.rready  = 1'b1;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < AXIL_WAIT_MAX) begin
        @(negedge clk);
        seen = axil_s2m.arready;
        @(posedge clk);
        cycles++;
    end
    #1;
    axil_m2s.arvalid = 1'b0;
    if (!seen) begin
        $display("Read of offset 0x%02h was never accepted (time %0t)", addr[7:0], $time);
        n_timeouts++;
    end
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < AXIL_WAIT_MAX) begin
        @(negedge clk);
        if (axil_s2m.rvalid) begin
            seen = 1'b1;
            data = axil_s2m.rdata;
            resp = axil_s2m.rresp;
        end
        @(posedge clk);
        cycles++;
    end
    #1;
    axil_m2s.rready = 1'b0;
    if (!seen) begin
        $display("Read of offset 0x%02h returned no data (time %0t)", addr[7:0], $time);
        n_timeouts++;
    end else begin
        queue_check($sformatf("RRESP of read of offset 0x%02h", addr[7:0]),
                    32'(resp), 32'(AXIL_RESP_OKAY));
    end
endtask

`endif

// ==== verification/tb_workgroup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "workgroup_consts.svh"

module tb_workgroup;

import workgroup_pkg::*;

localparam int CPU_NUM = 3;
localparam int IDLE_POLL_MAX = 2 * `WG_DPORT_TIMEOUT;
localparam logic [31:0] ADDR_CONTROL = 32'(`WG_ADDR_CONTROL);
localparam logic [31:0] ADDR_STATUS  = 32'(`WG_ADDR_STATUS);
localparam logic [31:0] ADDR_DADDR   = 32'(`WG_ADDR_DADDR);
localparam logic [31:0] ADDR_WDATA   = 32'(`WG_ADDR_WDATA);
localparam logic [31:0] ADDR_COMMAND = 32'(`WG_ADDR_COMMAND);
localparam logic [31:0] ADDR_RDATA   = 32'(`WG_ADDR_RDATA);

typedef struct packed {
    logic        error;
    logic        timeout;
    logic [31:0] rdata;
} expect_t;

logic clk = 1'b0;
logic rst_n;
axil_m2s_t axil_m2s;
axil_s2m_t axil_s2m;

logic [15:0] lfsr_q;
logic [31:0] model_regs [`WG_CPU_MAX][`WG_REG_TOTAL];
logic model_halted [`WG_CPU_MAX];
logic last_err;                                     // Flags of the last transaction
logic last_to;
int n_checks;
int n_errors;
int n_timeouts;
logic [31:0] got_q [$];
logic [31:0] exp_q [$];
string what_q [$];
logic [31:0] chk_got;
logic [31:0] chk_exp;
string chk_what;

workgroup #(
    .CPU_NUM(CPU_NUM)
) i_dut (
    .i_clk(clk),
    .i_rst_n(rst_n),
    .i_axil(axil_m2s),
    .o_axil(axil_s2m)
);

always #20 clk = ~clk;

`include "tb_axil_tasks.svh"

// x^16 + x^14 + x^13 + x^11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
        lfsr_q = lfsr_step(lfsr_q);
        v = {v[30:0], lfsr_q[0]};
    end
    return v;
endfunction

// Model of one debug access, also updates the hart registers
function automatic expect_t ref_access(input int hart, input logic write,
                                       input logic [3:0] idx, input logic [31:0] data);
    expect_t e;
    e = '0;
    if (hart >= CPU_NUM) begin
        e.error   = 1'b1;                           // Empty slot never answers
        e.timeout = 1'b1;
    end else if (write) begin
        e.error = !model_halted[hart];
        if (model_halted[hart]) begin
            model_regs[hart][idx] = data;
        end
    end else begin
        e.rdata = model_regs[hart][idx];
    end
    return e;
endfunction

function automatic logic [31:0] ref_status(input logic err, input logic to);
    logic [31:0] s;
    s = '0;
    for (int i = 0; i < `WG_CPU_MAX; i++) begin
        s[i]     = (i < CPU_NUM) && model_halted[i];
        s[8 + i] = (i < CPU_NUM);
    end
    s[17] = err;
    s[18] = to;
    return s;
endfunction

function automatic void ref_control(input int hart, input logic halt, input logic resume);
    if (hart < CPU_NUM) begin
        if (halt) begin
            model_halted[hart] = 1'b1;
        end else if (resume) begin
            model_halted[hart] = 1'b0;
        end
    end
endfunction

task automatic queue_check(input string what, input logic [31:0] got, input logic [31:0] exp);
    what_q.push_back(what);
    got_q.push_back(got);
    exp_q.push_back(exp);
endtask

// Comparison of everything the stimulus collected
always @(negedge clk) begin
    while (got_q.size() != 0) begin
        chk_what = what_q.pop_front();
        chk_got  = got_q.pop_front();
        chk_exp  = exp_q.pop_front();
        n_checks++;
        if (chk_got !== chk_exp) begin
            n_errors++;
            $display("** Error at %0d ns: %s is 0x%08h, expected 0x%08h",
                     $time, chk_what, chk_got, chk_exp);
        end
    end
end

task automatic wait_idle(output logic [31:0] status);
    int polls;
    status = 32'h0001_0000;
    polls  = 0;
    while (status[16] && polls < IDLE_POLL_MAX) begin
        axil_read(ADDR_STATUS, status);
        polls++;
    end
    if (status[16]) begin
        $display("Debug transaction still busy after %0d status polls", polls);
        n_timeouts++;
    end
endtask

task automatic set_control(input int hart, input logic halt, input logic resume);
    axil_write(ADDR_CONTROL, 32'(hart) | {26'd0, resume, halt, 4'd0});
    ref_control(hart, halt, resume);
endtask

task automatic run_access(input int hart, input logic write, input logic [3:0] idx,
                          input logic [31:0] data);
    expect_t exp;
    logic [31:0] status;
    logic [31:0] rdata;
    axil_write(ADDR_CONTROL, 32'(hart));           // Select only, no pulse
    axil_write(ADDR_DADDR, {28'd0, idx});
    axil_write(ADDR_WDATA, data);
    axil_write(ADDR_COMMAND, {31'd0, write});
    wait_idle(status);
    exp = ref_access(hart, write, idx, data);
    last_err = exp.error;
    last_to  = exp.timeout;
    queue_check($sformatf("STATUS after %s of hart %0d reg %0d", write ? "write" : "read",
                          hart, idx), status, ref_status(exp.error, exp.timeout));
    if (!write) begin
        axil_read(ADDR_RDATA, rdata);
        queue_check($sformatf("RDATA of hart %0d reg %0d", hart, idx), rdata, exp.rdata);
    end
endtask

initial begin
    logic [31:0] rd;
    logic [31:0] val;
    logic [3:0] idx_list [4];
    rst_n      = 1'b0;
    axil_m2s   = '0;
    lfsr_q     = 16'd40;
    last_err   = 1'b0;
    last_to    = 1'b0;
    n_checks   = 0;
    n_errors   = 0;
    n_timeouts = 0;
    for (int h = 0; h < `WG_CPU_MAX; h++) begin
        model_halted[h] = 1'b0;
        for (int r = 0; r < `WG_REG_TOTAL; r++) begin
            model_regs[h][r] = '0;
        end
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset state and plain register readback
    axil_read(ADDR_STATUS, rd);
    queue_check("STATUS after reset", rd, ref_status(1'b0, 1'b0));
    axil_write(ADDR_DADDR, 32'd9);
    axil_read(ADDR_DADDR, rd);
    queue_check("DADDR readback", rd, 32'd9);
    val = random_bits(32);
    axil_write(ADDR_WDATA, val);
    axil_read(ADDR_WDATA, rd);
    queue_check("WDATA readback", rd, val);

    run_access(1, 1'b1, 4'd6, random_bits(32));    // Hart 1 still running
    run_access(1, 1'b0, 4'd6, 32'd0);

    for (int h = 0; h < CPU_NUM; h++) begin
        set_control(h, 1'b1, 1'b0);
        axil_read(ADDR_STATUS, rd);
        queue_check($sformatf("STATUS after halt of hart %0d", h), rd,
                    ref_status(last_err, last_to));
        for (int k = 0; k < 4; k++) begin
            idx_list[k] = 4'(random_bits(4));
            run_access(h, 1'b1, idx_list[k], random_bits(32));
        end
        for (int k = 0; k < 4; k++) begin
            run_access(h, 1'b0, idx_list[k], 32'd0);
        end
    end

    run_access(3, 1'b0, 4'd0, 32'd0);               // Empty slot runs into the timeout

    set_control(1, 1'b0, 1'b1);
    axil_read(ADDR_STATUS, rd);
    queue_check("STATUS after resume of hart 1", rd, ref_status(last_err, last_to));
    run_access(1, 1'b1, idx_list[0], random_bits(32));
    run_access(1, 1'b0, idx_list[0], 32'd0);

    for (int n = 0; n < 4 && got_q.size() != 0; n++) begin
        @(posedge clk);
    end
    if (got_q.size() != 0) begin
        $display("Checker left %0d comparisons undone", got_q.size());
        n_timeouts++;
    end
    $display("Checks: %0d  errors: %0d  timeouts: %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0 && n_checks > 0) begin
        $display("TEST OK");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+source
+incdir+verification
source/workgroup_pkg.sv
source/dmi_axil_regs.sv
source/dport_fsm.sv
source/dport_timer.sv
source/dport_ic.sv
source/hart_dport.sv
source/workgroup.sv
verification/tb_workgroup.sv

// ==== Makefile ====
# Verilator flow for the workgroup debug subsystem
VERILATOR ?= verilator
TOP       ?= tb_workgroup
DUT_TOP   ?= workgroup
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FLIST) --top-module $(DUT_TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
